// File: hw/corr_settings.svh
`ifndef CORR_SETTINGS_SVH
`define CORR_SETTINGS_SVH

// Samples carried by one word of each channel.
`define CORR_DEMUX 16
// Raw code width of one sample.
`define CORR_INBITS 3
// Signed width of one expanded sample.
`define CORR_NBITS 6

// Correlations computed per block.
`define CORR_NCORRS 4

// Width of one square of a three-sample sum.
`define CORR_SQBITS 9
// Largest square, the sum of three samples of 7 squared.
`define CORR_MAX_SQUARE 441
// Width of the total of all squares in a word.
`define CORR_SUMBITS 13
// Largest total over the 16 slots.
`define CORR_MAX_SUM 7056

// Output and pedestal width.
`define CORR_POWERBITS 12

// Clock edges from an input word to its result.
`define CORR_LATENCY 5

`endif

// File: hw/corr_pkg.sv
`include "corr_settings.svh"

package corr_pkg;

	// One raw channel word, 16 codes of 3 bits.
	typedef logic [`CORR_DEMUX*`CORR_INBITS-1:0] raw_word_t;

	// One expanded sample.
	// Always odd, between -7 and +7.
	typedef logic signed [`CORR_NBITS-1:0] corr_sample_t;

	// Expanded word.
	// Slot 15 is the earliest sample, slot 0 the latest.
	typedef corr_sample_t [`CORR_DEMUX-1:0] corr_word_t;

	// One square per slot.
	typedef logic [`CORR_DEMUX-1:0][`CORR_SQBITS-1:0] square_word_t;

	// Unsigned total of the 16 squares.
	typedef logic [`CORR_SUMBITS-1:0] power_sum_t;

	// Pedestal or clamped output.
	typedef logic [`CORR_POWERBITS-1:0] power_t;

	// Lag layout of the four correlations.
	typedef enum logic [1:0] {
		TYPE_A,
		TYPE_B,
		TYPE_C
	} corr_type_e;

endpackage

// File: hw/sample_corrector.sv
`timescale 1ns/1ps
`include "corr_settings.svh"

module sample_corrector
	import corr_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  raw_word_t  a_word,
	input  raw_word_t  b_word,
	input  raw_word_t  c_word,
	output corr_word_t a_corr,
	output corr_word_t b_corr,
	output corr_word_t c_corr
);

	// Expanded words ahead of the register.
	corr_word_t a_next;
	corr_word_t b_next;
	corr_word_t c_next;
	// High once a real word sits in the register.
	logic loaded;
	// Low bit of every registered sample.
	logic [3*`CORR_DEMUX-1:0] lsbs;

	// Doubles the code and removes the offset of 7.
	function automatic corr_sample_t expand(input logic [`CORR_INBITS-1:0] code);
		corr_sample_t doubled;
		doubled = corr_sample_t'({code, 1'b0});
		return doubled - corr_sample_t'((1 << `CORR_INBITS) - 1);
	endfunction

	// Expand every slot of all three channels.
	always_comb begin
		for (int j = 0; j < `CORR_DEMUX; j++) begin
			a_next[j] = expand(a_word[j*`CORR_INBITS +: `CORR_INBITS]);
			b_next[j] = expand(b_word[j*`CORR_INBITS +: `CORR_INBITS]);
			c_next[j] = expand(c_word[j*`CORR_INBITS +: `CORR_INBITS]);
		end
	end

	// Pipeline stage 1.
	// Reset value is 0, not -7.
	always_ff @(posedge clk) begin
		if (rst) begin
			a_corr <= '0;
			b_corr <= '0;
			c_corr <= '0;
			loaded <= 1'b0;
		end else begin
			a_corr <= a_next;
			b_corr <= b_next;
			c_corr <= c_next;
			loaded <= 1'b1;
		end
	end

	// Gather parity bits for the check below.
	always_comb begin
		for (int j = 0; j < `CORR_DEMUX; j++) begin
			lsbs[j] = a_corr[j][0];
			lsbs[`CORR_DEMUX+j] = b_corr[j][0];
			lsbs[2*`CORR_DEMUX+j] = c_corr[j][0];
		end
	end

	// Every expanded sample is odd after the first word.
	a_samples_odd: assert property (@(posedge clk) disable iff (rst) loaded |-> &lsbs)
		else $error("sample_corrector: even sample in registered word");

endmodule

// File: hw/lag_selector.sv
`timescale 1ns/1ps
`include "corr_settings.svh"

module lag_selector
	import corr_pkg::*;
#(
	parameter corr_type_e corr_type = TYPE_A
) (
	input  logic                           clk,
	input  logic                           rst,
	input  corr_word_t                     a_corr,
	input  corr_word_t                     b_corr,
	input  corr_word_t                     c_corr,
	output corr_word_t [`CORR_NCORRS-1:0] a_lag,
	output corr_word_t [`CORR_NCORRS-1:0] b_lag,
	output corr_word_t [`CORR_NCORRS-1:0] c_lag
);

	// B lag of each correlation.
	// Packed as correlation 3 down to 0.
	localparam logic [`CORR_NCORRS-1:0][1:0] b_lags =
		(corr_type == TYPE_A) ? {2'd1, 2'd1, 2'd0, 2'd0} :
		(corr_type == TYPE_B) ? {2'd1, 2'd0, 2'd0, 2'd0} :
		                        {2'd1, 2'd1, 2'd1, 2'd0};

	// C lag of each correlation.
	localparam logic [`CORR_NCORRS-1:0][1:0] c_lags =
		(corr_type == TYPE_A) ? {2'd2, 2'd1, 2'd1, 2'd0} :
		(corr_type == TYPE_B) ? {2'd2, 2'd2, 2'd1, 2'd0} :
		                        {2'd2, 2'd1, 2'd0, 2'd0};

	// Slot 0 of the previous B word.
	corr_sample_t b_hist;
	// Slots 1 and 0 of the previous C word.
	corr_sample_t [1:0] c_hist;

	// Lagged words.
	corr_word_t b_lag1;
	corr_word_t c_lag1;
	corr_word_t c_lag2;

	// History follows the registered words every cycle.
	always_ff @(posedge clk) begin
		if (rst) begin
			b_hist <= '0;
			c_hist <= '0;
		end else begin
			b_hist <= b_corr[0];
			c_hist <= c_corr[1:0];
		end
	end

	// Slot j takes slot j+L.
	// Slots past 15 come from the previous word.
	assign b_lag1 = {b_hist, b_corr[`CORR_DEMUX-1:1]};
	assign c_lag1 = {c_hist[0], c_corr[`CORR_DEMUX-1:1]};
	// Previous slot 1 lands in slot 15, previous slot 0 in slot 14.
	assign c_lag2 = {c_hist, c_corr[`CORR_DEMUX-1:2]};

	// Route one lag per channel to each correlation.
	always_comb begin
		for (int i = 0; i < `CORR_NCORRS; i++) begin
			// A is never lagged.
			a_lag[i] = a_corr;
			// B only ever uses lag 0 or 1.
			case (b_lags[i])
				2'd0:    b_lag[i] = b_corr;
				default: b_lag[i] = b_lag1;
			endcase
			case (c_lags[i])
				2'd0:    c_lag[i] = c_corr;
				2'd1:    c_lag[i] = c_lag1;
				default: c_lag[i] = c_lag2;
			endcase
		end
	end

endmodule

// File: hw/add_square.sv
`timescale 1ns/1ps
`include "corr_settings.svh"

module add_square
	import corr_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  corr_word_t   a_lag,
	input  corr_word_t   b_lag,
	input  corr_word_t   c_lag,
	output square_word_t squares
);

	// Three-sample sum per slot, -21 to +21.
	logic signed [`CORR_NBITS:0] slot_sum [`CORR_DEMUX];
	// Full signed product of each sum with itself.
	logic signed [2*`CORR_NBITS+1:0] slot_sq [`CORR_DEMUX];
	// Squares ahead of the register.
	square_word_t sq_next;
	// Bound check on each registered square.
	logic [`CORR_DEMUX-1:0] sq_in_range;

	// Add and square each slot.
	always_comb begin
		for (int j = 0; j < `CORR_DEMUX; j++) begin
			slot_sum[j] = $signed(a_lag[j]) + $signed(b_lag[j]) + $signed(c_lag[j]);
			slot_sq[j] = slot_sum[j] * slot_sum[j];
			// Square is never negative.
			// Nine bits hold 441.
			sq_next[j] = slot_sq[j][`CORR_SQBITS-1:0];
		end
	end

	// Pipeline stage 2.
	always_ff @(posedge clk) begin
		if (rst) begin
			squares <= '0;
		end else begin
			squares <= sq_next;
		end
	end

	always_comb begin
		for (int j = 0; j < `CORR_DEMUX; j++) begin
			sq_in_range[j] = (squares[j] <= `CORR_MAX_SQUARE);
		end
	end

	// Lagged inputs stay within the expansion range.
	a_square_bound: assert property (@(posedge clk) disable iff (rst) &sq_in_range)
		else $error("add_square: square above %0d", `CORR_MAX_SQUARE);

endmodule

// File: hw/square_sum_tree.sv
`timescale 1ns/1ps
`include "corr_settings.svh"

module square_sum_tree
	import corr_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  square_word_t squares,
	output power_sum_t   total
);

	// Squares added in each first-stage group.
	localparam int group_size = 4;
	// Number of first-stage groups.
	localparam int n_groups = `CORR_DEMUX / group_size;

	// Partial sums reach 4*441, so 11 bits.
	logic [`CORR_SQBITS+1:0] part_next [n_groups];
	logic [`CORR_SQBITS+1:0] part_q [n_groups];
	// Full total ahead of the second register.
	power_sum_t total_next;

	// Stage 1 adders.
	always_comb begin
		for (int g = 0; g < n_groups; g++) begin
			part_next[g] = '0;
			for (int k = 0; k < group_size; k++) begin
				part_next[g] = part_next[g] + squares[group_size*g+k];
			end
		end
	end

	// Pipeline stage 3.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int g = 0; g < n_groups; g++) begin
				part_q[g] <= '0;
			end
		end else begin
			for (int g = 0; g < n_groups; g++) begin
				part_q[g] <= part_next[g];
			end
		end
	end

	// Stage 2 adder.
	always_comb begin
		total_next = '0;
		for (int g = 0; g < n_groups; g++) begin
			total_next = total_next + part_q[g];
		end
	end

	// Pipeline stage 4.
	always_ff @(posedge clk) begin
		if (rst) begin
			total <= '0;
		end else begin
			total <= total_next;
		end
	end

	// Sixteen bounded squares cannot exceed 7056.
	a_total_bound: assert property (@(posedge clk) disable iff (rst)
		total <= `CORR_MAX_SUM)
		else $error("square_sum_tree: total %0d above %0d", total, `CORR_MAX_SUM);

endmodule

// File: hw/pedestal_subtract.sv
`timescale 1ns/1ps
`include "corr_settings.svh"

module pedestal_subtract
	import corr_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  power_sum_t total,
	input  power_t     ped,
	output power_t     power
);

	// Top of the output range.
	localparam int power_max = (1 << `CORR_POWERBITS) - 1;

	// One extra bit for the sign.
	logic signed [`CORR_SUMBITS:0] diff;
	// Result ahead of the register.
	power_t clamped;

	// Subtract and saturate.
	always_comb begin
		diff = $signed({1'b0, total})
			- $signed({{(`CORR_SUMBITS-`CORR_POWERBITS+1){1'b0}}, ped});
		if (diff < 0) begin
			// Pedestal above the total.
			clamped = '0;
		end else if (diff > power_max) begin
			// Totals up to 7056 overflow 12 bits.
			clamped = '1;
		end else begin
			clamped = diff[`CORR_POWERBITS-1:0];
		end
	end

	// Pipeline stage 5.
	// Pedestal is taken at this edge.
	always_ff @(posedge clk) begin
		if (rst) begin
			power <= '0;
		end else begin
			power <= clamped;
		end
	end

endmodule

// File: hw/corr_top.sv
`timescale 1ns/1ps
`include "corr_settings.svh"

module corr_top
	import corr_pkg::*;
#(
	parameter corr_type_e corr_type = TYPE_A
) (
	input  logic      clk,
	input  logic      rst,
	input  raw_word_t a_word,
	input  raw_word_t b_word,
	input  raw_word_t c_word,
	input  power_t    ped0,
	input  power_t    ped1,
	input  power_t    ped2,
	input  power_t    ped3,
	output power_t    corr0,
	output power_t    corr1,
	output power_t    corr2,
	output power_t    corr3
);

	// Expanded words, one cycle after the inputs.
	corr_word_t a_corr;
	corr_word_t b_corr;
	corr_word_t c_corr;
	// Per-correlation lagged words.
	corr_word_t [`CORR_NCORRS-1:0] a_lag;
	corr_word_t [`CORR_NCORRS-1:0] b_lag;
	corr_word_t [`CORR_NCORRS-1:0] c_lag;
	// Pedestals and results indexed by correlation.
	power_t ped [`CORR_NCORRS];
	power_t power [`CORR_NCORRS];

	assign ped[0] = ped0;
	assign ped[1] = ped1;
	assign ped[2] = ped2;
	assign ped[3] = ped3;

	assign corr0 = power[0];
	assign corr1 = power[1];
	assign corr2 = power[2];
	assign corr3 = power[3];

	// Shared front end.
	sample_corrector i_sample_corrector (
		.clk    (clk),
		.rst    (rst),
		.a_word (a_word),
		.b_word (b_word),
		.c_word (c_word),
		.a_corr (a_corr),
		.b_corr (b_corr),
		.c_corr (c_corr)
	);

	// Lag table follows the correlation type.
	lag_selector #(
		.corr_type (corr_type)
	) i_lag_selector (
		.clk    (clk),
		.rst    (rst),
		.a_corr (a_corr),
		.b_corr (b_corr),
		.c_corr (c_corr),
		.a_lag  (a_lag),
		.b_lag  (b_lag),
		.c_lag  (c_lag)
	);

	// One square, sum and pedestal chain per correlation.
	for (genvar i = 0; i < `CORR_NCORRS; i++) begin : g_chain
		square_word_t squares;
		power_sum_t   total;

		add_square i_add_square (
			.clk     (clk),
			.rst     (rst),
			.a_lag   (a_lag[i]),
			.b_lag   (b_lag[i]),
			.c_lag   (c_lag[i]),
			.squares (squares)
		);

		square_sum_tree i_square_sum_tree (
			.clk     (clk),
			.rst     (rst),
			.squares (squares),
			.total   (total)
		);

		pedestal_subtract i_pedestal_subtract (
			.clk   (clk),
			.rst   (rst),
			.total (total),
			.ped   (ped[i]),
			.power (power[i])
		);
	end

endmodule

// File: verif/tb_corr_top.sv
`timescale 1ns/1ps
`include "corr_settings.svh"

module tb_corr_top
	import corr_pkg::*;
();

	// Run limit well above the length of all phases.
	localparam int max_cycles = 600;
	// Model history reaches one word past the pipeline depth.
	localparam int hist_depth = `CORR_LATENCY + 1;

	// (B, C) lags per type and correlation.
	localparam int b_lag_table [3][4] = '{'{0, 0, 1, 1}, '{0, 0, 0, 1}, '{0, 1, 1, 1}};
	localparam int c_lag_table [3][4] = '{'{0, 1, 1, 2}, '{0, 1, 2, 2}, '{0, 0, 1, 2}};

	logic      clk;
	logic      rst;
	raw_word_t a_word;
	raw_word_t b_word;
	raw_word_t c_word;
	power_t    ped0;
	power_t    ped1;
	power_t    ped2;
	power_t    ped3;

	// Model compare is active.
	logic check_en;
	// Outputs must still read zero.
	logic zero_window;
	logic [31:0] lfsr;
	int cycle_count = 0;

	// Input words as seen at each edge.
	// Entry 0 is the newest.
	raw_word_t a_hist [hist_depth] = '{default: '0};
	raw_word_t b_hist [hist_depth] = '{default: '0};
	raw_word_t c_hist [hist_depth] = '{default: '0};
	// Set where the word was taken during reset.
	logic [hist_depth-1:0] zero_hist = '1;
	// Pedestals taken at the last edge.
	power_t [3:0] ped_q = '0;
	// Predicted output per type and correlation.
	power_t [3:0] expected [3];

	// 100 ns clock.
	always #50 clk = ~clk;

	// Reports an error and ends the run.
	task automatic stop_with_failure(input string line);
		$display("%s", line);
		$display("TB FAILED");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	// Fibonacci LFSR with taps 32 22 2 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// One LFSR step per bit of the word.
	task automatic next_random_word(output raw_word_t w);
		for (int b = 0; b < `CORR_DEMUX*`CORR_INBITS; b++) begin
			lfsr = lfsr_step(lfsr);
			w[b] = lfsr[0];
		end
	endtask

	// Same code in every slot.
	function automatic raw_word_t fill_word(input int code);
		raw_word_t w;
		for (int j = 0; j < `CORR_DEMUX; j++) begin
			w[j*`CORR_INBITS +: `CORR_INBITS] = code[`CORR_INBITS-1:0];
		end
		return w;
	endfunction

	// Value 2*code - 7.
	// A word lost to reset reads 0.
	function automatic int sample_value(input raw_word_t w, input logic zero, input int slot);
		if (zero) begin
			return 0;
		end
		return 2 * int'(w[slot*`CORR_INBITS +: `CORR_INBITS]) - 7;
	endfunction

	// Slot j pairs with slot j+lag of the same or the previous word.
	function automatic int lagged_value(input raw_word_t cur, input raw_word_t prev,
		input logic cur_zero, input logic prev_zero, input int slot, input int lag);
		int idx;
		idx = slot + lag;
		if (idx < `CORR_DEMUX) begin
			return sample_value(cur, cur_zero, idx);
		end
		return sample_value(prev, prev_zero, idx - `CORR_DEMUX);
	endfunction

	// Sum of squares less the pedestal.
	// Clamped to 12 bits.
	function automatic power_t model_power(input int t, input int n,
		input raw_word_t a_cur, input raw_word_t b_cur, input raw_word_t b_prev,
		input raw_word_t c_cur, input raw_word_t c_prev,
		input logic cur_zero, input logic prev_zero, input power_t ped);
		int total;
		int s;
		int diff;
		total = 0;
		for (int j = 0; j < `CORR_DEMUX; j++) begin
			s = sample_value(a_cur, cur_zero, j);
			s += lagged_value(b_cur, b_prev, cur_zero, prev_zero, j, b_lag_table[t][n]);
			s += lagged_value(c_cur, c_prev, cur_zero, prev_zero, j, c_lag_table[t][n]);
			total += s * s;
		end
		diff = total - int'(ped);
		if (diff < 0) begin
			return '0;
		end else if (diff > 4095) begin
			return power_t'(4095);
		end
		return power_t'(diff);
	endfunction

	// Shift in the words the DUTs take at this edge.
	always @(posedge clk) begin
		for (int k = hist_depth - 1; k > 0; k--) begin
			a_hist[k] <= a_hist[k-1];
			b_hist[k] <= b_hist[k-1];
			c_hist[k] <= c_hist[k-1];
		end
		a_hist[0] <= a_word;
		b_hist[0] <= b_word;
		c_hist[0] <= c_word;
		zero_hist <= {zero_hist[hist_depth-2:0], rst};
		ped_q <= {ped3, ped2, ped1, ped0};
	end

	// Output after an edge holds the word of 4 edges before.
	always_comb begin
		for (int t = 0; t < 3; t++) begin
			for (int n = 0; n < `CORR_NCORRS; n++) begin
				expected[t][n] = model_power(t, n, a_hist[4], b_hist[4], b_hist[5],
					c_hist[4], c_hist[5], zero_hist[4], zero_hist[5], ped_q[n]);
			end
		end
	end

	// One DUT per correlation type.
	for (genvar t = 0; t < 3; t++) begin : g_type
		localparam corr_type_e dut_type = (t == 0) ? TYPE_A : (t == 1) ? TYPE_B : TYPE_C;
		power_t [3:0] dut_out;

		corr_top #(
			.corr_type (dut_type)
		) i_dut (
			.clk    (clk),
			.rst    (rst),
			.a_word (a_word),
			.b_word (b_word),
			.c_word (c_word),
			.ped0   (ped0),
			.ped1   (ped1),
			.ped2   (ped2),
			.ped3   (ped3),
			.corr0  (dut_out[0]),
			.corr1  (dut_out[1]),
			.corr2  (dut_out[2]),
			.corr3  (dut_out[3])
		);

		for (genvar n = 0; n < `CORR_NCORRS; n++) begin : g_check
			a_model_match: assert property (@(posedge clk)
				check_en |-> dut_out[n] == expected[t][n])
				else stop_with_failure($sformatf(
					"FAIL %0t: type %0d corr%0d is %0d, expected %0d",
					$time, t, n, $sampled(dut_out[n]), $sampled(expected[t][n])));
			a_zero_after_reset: assert property (@(posedge clk)
				zero_window |-> dut_out[n] == '0)
				else stop_with_failure($sformatf(
					"FAIL %0t: type %0d corr%0d is %0d after reset",
					$time, t, n, $sampled(dut_out[n])));
		end
	end

	// Hard stop on a stuck run.
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			stop_with_failure($sformatf("Timeout: test did not finish within %0d cycles",
				max_cycles));
		end
	end

	// One word per channel at the next edge.
	task automatic drive_words(input raw_word_t a, input raw_word_t b, input raw_word_t c);
		@(posedge clk);
		a_word <= a;
		b_word <= b;
		c_word <= c;
	endtask

	// Load new pedestals and let the pipeline settle.
	task automatic change_peds(input int p0, input int p1, input int p2, input int p3);
		@(posedge clk);
		check_en <= 1'b0;
		ped0 <= power_t'(p0);
		ped1 <= power_t'(p1);
		ped2 <= power_t'(p2);
		ped3 <= power_t'(p3);
		repeat (`CORR_LATENCY) @(posedge clk);
		check_en <= 1'b1;
	endtask

	task automatic run_random(input int cycles);
		raw_word_t a;
		raw_word_t b;
		raw_word_t c;
		repeat (cycles) begin
			next_random_word(a);
			next_random_word(b);
			next_random_word(c);
			drive_words(a, b, c);
		end
	endtask

	task automatic run_constant(input int a_code, input int b_code, input int c_code,
		input int cycles);
		repeat (cycles) begin
			drive_words(fill_word(a_code), fill_word(b_code), fill_word(c_code));
		end
	endtask

	// Two fixed words per channel swapped every cycle.
	task automatic run_alternating(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			if (i % 2 == 0) begin
				drive_words(48'h5A3C_96E1_0F72, 48'h1234_5678_9ABC, 48'h0F0F_F0F0_3C3C);
			end else begin
				drive_words(48'hA5C3_691E_F08D, 48'hEDCB_A987_6543, 48'h7E81_18E7_C33C);
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		a_word = '0;
		b_word = '0;
		c_word = '0;
		ped0 = '0;
		ped1 = '0;
		ped2 = '0;
		ped3 = '0;
		check_en = 1'b0;
		zero_window = 1'b0;
		lfsr = 32'd89240;

		// Reset for 5 cycles.
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		check_en <= 1'b1;
		zero_window <= 1'b1;
		// Pipeline still holds reset zeros.
		repeat (`CORR_LATENCY) @(posedge clk);
		zero_window <= 1'b0;

		// Random traffic with zero pedestals.
		run_random(200);
		// All codes 0 saturate every output.
		run_constant(0, 0, 0, 20);

		// Nonzero pedestals.
		change_peds(1000, 2500, 300, 3900);
		run_random(80);
		run_constant(5, 5, 5, 20);

		// Slot sums of -1 under a full pedestal clamp to 0.
		change_peds(4095, 4095, 4095, 4095);
		run_constant(3, 4, 3, 20);

		// Lag tables differ on corr1 and corr2.
		change_peds(0, 0, 0, 0);
		run_alternating(40);

		// Drain the last words.
		// The final result is compared one edge after it appears.
		repeat (`CORR_LATENCY + 2) @(posedge clk);
		$display("TB PASSED");
		$finish;
	end

endmodule

// File: compile.f
+incdir+hw
hw/corr_pkg.sv
hw/sample_corrector.sv
hw/lag_selector.sv
hw/add_square.sv
hw/square_sum_tree.sv
hw/pedestal_subtract.sv
hw/corr_top.sv
verif/tb_corr_top.sv

// File: Bender.yml
package:
  name: corr_top

sources:
  - include_dirs:
      - hw
    files:
      - hw/corr_pkg.sv
      - hw/sample_corrector.sv
      - hw/lag_selector.sv
      - hw/add_square.sv
      - hw/square_sum_tree.sv
      - hw/pedestal_subtract.sv
      - hw/corr_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/tb_corr_top.sv
